//--- design/lc4_settings.svh
// LC4 pipeline widths and boot values
`default_nettype none
`ifndef LC4_SETTINGS_SVH
`define LC4_SETTINGS_SVH

`define LC4_WORD_W     16        // Data and address width
`define LC4_RESET_PC   16'h8200  // Boot address
`define LC4_NUM_REGS   8
`define LC4_REG_SEL_W  3

`endif
`default_nettype wire

//--- design/lc4_isa_pkg.sv
// LC4 instruction encodings
`include "lc4_settings.svh"
`default_nettype none

package lc4_isa_pkg;

   // Opcodes in insn[15:12], only the kept subset is named
   typedef enum logic [3:0] {
      OP_NOP   = 4'b0000,
      OP_ARITH = 4'b0001,  // ADD, SUB, ADD imm
      OP_LDR   = 4'b0110,
      OP_STR   = 4'b0111,
      OP_CONST = 4'b1001
   } opcode_e;

   // Arith sub-op in insn[5:3], bit 5 set means immediate form
   typedef enum logic [2:0] {
      SUB_ADD = 3'b000,
      SUB_SUB = 3'b010
   } arith_sub_e;

   typedef struct packed {
      opcode_e                   op;
      logic [`LC4_REG_SEL_W-1:0] rd;
      logic [`LC4_REG_SEL_W-1:0] rs;
      arith_sub_e                sub;
      logic [`LC4_REG_SEL_W-1:0] rt;
   } rtype_t;

   typedef struct packed {
      opcode_e                   op;
      logic [`LC4_REG_SEL_W-1:0] rd;
      logic [`LC4_REG_SEL_W-1:0] rs;
      logic [5:0]                imm6;  // imm5 and imm9 are cut from here
   } itype_t;

   // Same word, register view or immediate view
   typedef union packed {
      rtype_t rtype;
      itype_t itype;
   } insn_u;

endpackage
`default_nettype wire

//--- design/lc4_pipe_pkg.sv
// LC4 pipeline control types
`include "lc4_settings.svh"
`default_nettype none

package lc4_pipe_pkg;

   typedef struct packed {
      logic [`LC4_REG_SEL_W-1:0] r1sel;       // rs
      logic                      r1re;
      logic [`LC4_REG_SEL_W-1:0] r2sel;       // rt, or store data reg
      logic                      r2re;
      logic [`LC4_REG_SEL_W-1:0] wsel;
      logic                      regfile_we;
      logic                      nzp_we;
      logic                      is_load;
      logic                      is_store;
      logic                      valid;       // Low for bubbles and empty slots
   } ctrl_t;

   // Operand source in X
   typedef enum logic [1:0] {BYP_REG = 2'd0, BYP_M = 2'd1, BYP_W = 2'd2} byp_e;

endpackage
`default_nettype wire

//--- design/lc4_hazard_if.sv
// Hazard information between pipeline stages
`timescale 1ns/1ps
`include "lc4_settings.svh"
`default_nettype none

interface lc4_hazard_if;
   logic [`LC4_REG_SEL_W-1:0] d_r1sel, d_r2sel;
   logic                      d_r1re, d_r2re, d_is_store;
   logic [`LC4_REG_SEL_W-1:0] x_wsel, x_r1sel, x_r2sel;
   logic                      x_regfile_we, x_is_load;
   logic [`LC4_REG_SEL_W-1:0] m_wsel, m_r2sel, w_wsel;
   logic                      m_regfile_we, m_is_store, w_regfile_we;
   logic                      stall;           // Load-use, hold F and D
   lc4_pipe_pkg::byp_e        byp_rs, byp_rt;  // X operand sources
   logic                      byp_st;          // W data into M store

   modport decode  (output d_r1sel, d_r1re, d_r2sel, d_r2re, d_is_store, input stall);
   modport execute (output x_wsel, x_regfile_we, x_is_load, x_r1sel, x_r2sel,
                    input stall, byp_rs, byp_rt);
   modport memwb   (output m_wsel, m_regfile_we, m_is_store, m_r2sel, w_wsel, w_regfile_we,
                    input byp_st);
   modport ctrl    (input d_r1sel, d_r1re, d_r2sel, d_r2re, d_is_store,
                    x_wsel, x_regfile_we, x_is_load, x_r1sel, x_r2sel,
                    m_wsel, m_regfile_we, m_is_store, m_r2sel, w_wsel, w_regfile_we,
                    output stall, byp_rs, byp_rt, byp_st);
endinterface
`default_nettype wire

//--- design/lc4_hazard_ctrl.sv
// Load-use stall and bypass select
`timescale 1ns/1ps
`include "lc4_settings.svh"
`default_nettype none

module lc4_hazard_ctrl (
   lc4_hazard_if.ctrl hz
);

   // Youngest producer wins, M before W
   function automatic lc4_pipe_pkg::byp_e pick_src(
      input logic [`LC4_REG_SEL_W-1:0] sel,
      input logic                      m_we,
      input logic [`LC4_REG_SEL_W-1:0] m_wsel,
      input logic                      w_we,
      input logic [`LC4_REG_SEL_W-1:0] w_wsel
   );
      if (m_we && m_wsel == sel)
         return lc4_pipe_pkg::BYP_M;
      else if (w_we && w_wsel == sel)
         return lc4_pipe_pkg::BYP_W;
      else
         return lc4_pipe_pkg::BYP_REG;
   endfunction

   logic hit_r1, hit_r2;

   // Store data is exempt, it is picked up from W in M instead
   assign hit_r1 = hz.d_r1re && (hz.d_r1sel == hz.x_wsel);
   assign hit_r2 = hz.d_r2re && (hz.d_r2sel == hz.x_wsel) && !hz.d_is_store;
   assign hz.stall = hz.x_is_load && hz.x_regfile_we && (hit_r1 || hit_r2);

   always_comb begin
      hz.byp_rs = pick_src(hz.x_r1sel, hz.m_regfile_we, hz.m_wsel, hz.w_regfile_we, hz.w_wsel);
      hz.byp_rt = pick_src(hz.x_r2sel, hz.m_regfile_we, hz.m_wsel, hz.w_regfile_we, hz.w_wsel);
   end

   assign hz.byp_st = hz.w_regfile_we && hz.m_is_store && (hz.w_wsel == hz.m_r2sel); // WM

endmodule
`default_nettype wire

//--- design/lc4_fetch_decode.sv
// Fetch, decode latch, decoder and register file
`timescale 1ns/1ps
`include "lc4_settings.svh"
`default_nettype none

module lc4_fetch_decode (
   input  wire                            gwe,
   input  wire                            i_rst_n,
   input  wire  [`LC4_WORD_W-1:0]         i_imem_data,
   input  wire                            i_wb_we,
   input  wire  [`LC4_REG_SEL_W-1:0]      i_wb_wsel,
   input  wire  [`LC4_WORD_W-1:0]         i_wb_data,
   output logic [`LC4_WORD_W-1:0]         o_imem_addr,
   output lc4_pipe_pkg::ctrl_t            o_d_ctrl,
   output logic [`LC4_WORD_W-1:0]         o_d_pc,
   output lc4_isa_pkg::insn_u             o_d_insn,
   output logic [`LC4_WORD_W-1:0]         o_rs_data,
   output logic [`LC4_WORD_W-1:0]         o_rt_data,
   lc4_hazard_if.decode                   hz
);

   logic [`LC4_WORD_W-1:0] pc;
   logic                   d_valid;
   logic [`LC4_WORD_W-1:0] regs [`LC4_NUM_REGS];

   always_ff @(posedge gwe) begin
      if (!i_rst_n) begin
         pc      <= `LC4_RESET_PC;
         d_valid <= 1'b0;
      end else if (!hz.stall) begin
         pc      <= pc + `LC4_WORD_W'(1);  // No redirects in this subset
         d_valid <= 1'b1;
      end
   end

   always_ff @(posedge gwe) begin
      if (!hz.stall) begin  // D holds its insn on load-use
         o_d_insn <= i_imem_data;
         o_d_pc   <= pc;
      end
   end

   assign o_imem_addr = pc;

   always_comb begin
      o_d_ctrl       = '0;
      o_d_ctrl.valid = d_valid;
      o_d_ctrl.r1sel = o_d_insn.rtype.rs;
      o_d_ctrl.r2sel = o_d_insn.rtype.rt;
      o_d_ctrl.wsel  = o_d_insn.rtype.rd;
      if (d_valid) begin
         case (o_d_insn.rtype.op)
            lc4_isa_pkg::OP_ARITH: begin
               // Imm form, or register form with a supported sub-op
               if (o_d_insn.itype.imm6[5] || o_d_insn.rtype.sub == lc4_isa_pkg::SUB_ADD ||
                   o_d_insn.rtype.sub == lc4_isa_pkg::SUB_SUB) begin
                  o_d_ctrl.r1re       = 1'b1;
                  o_d_ctrl.r2re       = !o_d_insn.itype.imm6[5];
                  o_d_ctrl.regfile_we = 1'b1;
                  o_d_ctrl.nzp_we     = 1'b1;
               end
            end
            lc4_isa_pkg::OP_CONST: begin
               o_d_ctrl.regfile_we = 1'b1;
               o_d_ctrl.nzp_we     = 1'b1;
            end
            lc4_isa_pkg::OP_LDR: begin
               o_d_ctrl.r1re       = 1'b1;  // Base
               o_d_ctrl.regfile_we = 1'b1;
               o_d_ctrl.nzp_we     = 1'b1;
               o_d_ctrl.is_load    = 1'b1;
            end
            lc4_isa_pkg::OP_STR: begin
               o_d_ctrl.r1re     = 1'b1;
               o_d_ctrl.r2sel    = o_d_insn.rtype.rd;  // Store data sits in rd field
               o_d_ctrl.r2re     = 1'b1;
               o_d_ctrl.is_store = 1'b1;
            end
            default: ;  // Retires as NOP
         endcase
      end
   end

   always_ff @(posedge gwe) begin
      if (i_wb_we)
         regs[i_wb_wsel] <= i_wb_data;
   end

   // Same-cycle write forwarded to the reads
   assign o_rs_data = (i_wb_we && i_wb_wsel == o_d_ctrl.r1sel) ? i_wb_data : regs[o_d_ctrl.r1sel];
   assign o_rt_data = (i_wb_we && i_wb_wsel == o_d_ctrl.r2sel) ? i_wb_data : regs[o_d_ctrl.r2sel];

   assign hz.d_r1sel    = o_d_ctrl.r1sel;
   assign hz.d_r1re     = o_d_ctrl.r1re;
   assign hz.d_r2sel    = o_d_ctrl.r2sel;
   assign hz.d_r2re     = o_d_ctrl.r2re;
   assign hz.d_is_store = o_d_ctrl.is_store;

endmodule
`default_nettype wire

//--- design/lc4_execute.sv
// Execute stage, bypass muxes and ALU
`timescale 1ns/1ps
`include "lc4_settings.svh"
`default_nettype none

module lc4_execute (
   input  wire                            gwe,
   input  wire                            i_rst_n,
   input  wire  lc4_pipe_pkg::ctrl_t      i_d_ctrl,
   input  wire  [`LC4_WORD_W-1:0]         i_d_pc,
   input  wire  lc4_isa_pkg::insn_u       i_d_insn,
   input  wire  [`LC4_WORD_W-1:0]         i_rs_data,
   input  wire  [`LC4_WORD_W-1:0]         i_rt_data,
   input  wire  [`LC4_WORD_W-1:0]         i_m_alu,
   input  wire  [`LC4_WORD_W-1:0]         i_w_data,
   output lc4_pipe_pkg::ctrl_t            o_x_ctrl,
   output logic [`LC4_WORD_W-1:0]         o_x_pc,
   output logic [`LC4_WORD_W-1:0]         o_x_alu,
   output logic [2:0]                     o_x_nzp,
   output logic [`LC4_WORD_W-1:0]         o_x_rt,
   lc4_hazard_if.execute                  hz
);

   lc4_isa_pkg::insn_u     x_insn;
   logic [`LC4_WORD_W-1:0] x_rs, x_rt, rs_op;
   logic [`LC4_WORD_W-1:0] imm5_sx, imm6_sx, imm9_sx, arith_b;

   always_ff @(posedge gwe) begin
      if (!i_rst_n || hz.stall)
         o_x_ctrl <= '0;  // Bubble on load-use
      else
         o_x_ctrl <= i_d_ctrl;
   end

   always_ff @(posedge gwe) begin
      o_x_pc <= i_d_pc;
      x_insn <= i_d_insn;
      x_rs   <= i_rs_data;
      x_rt   <= i_rt_data;
   end

   always_comb begin
      case (hz.byp_rs)
         lc4_pipe_pkg::BYP_M: rs_op = i_m_alu;   // MX
         lc4_pipe_pkg::BYP_W: rs_op = i_w_data;  // WX
         default:             rs_op = x_rs;
      endcase
      case (hz.byp_rt)
         lc4_pipe_pkg::BYP_M: o_x_rt = i_m_alu;
         lc4_pipe_pkg::BYP_W: o_x_rt = i_w_data;
         default:             o_x_rt = x_rt;
      endcase
   end

   assign imm5_sx = {{11{x_insn.itype.imm6[4]}}, x_insn.itype.imm6[4:0]};
   assign imm6_sx = {{10{x_insn.itype.imm6[5]}}, x_insn.itype.imm6};
   assign imm9_sx = {{7{x_insn.itype.rs[2]}}, x_insn.itype.rs, x_insn.itype.imm6};
   assign arith_b = x_insn.itype.imm6[5] ? imm5_sx : o_x_rt;

   always_comb begin
      case (x_insn.rtype.op)
         lc4_isa_pkg::OP_ARITH:
            if (!x_insn.itype.imm6[5] && x_insn.rtype.sub == lc4_isa_pkg::SUB_SUB)
               o_x_alu = rs_op - arith_b;
            else
               o_x_alu = rs_op + arith_b;
         lc4_isa_pkg::OP_CONST: o_x_alu = imm9_sx;
         lc4_isa_pkg::OP_LDR,
         lc4_isa_pkg::OP_STR:   o_x_alu = rs_op + imm6_sx;  // Effective address
         default:               o_x_alu = '0;
      endcase
   end

   assign o_x_nzp = {o_x_alu[15], o_x_alu == '0, !o_x_alu[15] && o_x_alu != '0};

   assign hz.x_wsel       = o_x_ctrl.wsel;
   assign hz.x_regfile_we = o_x_ctrl.regfile_we;
   assign hz.x_is_load    = o_x_ctrl.is_load;
   assign hz.x_r1sel      = o_x_ctrl.r1sel;
   assign hz.x_r2sel      = o_x_ctrl.r2sel;

endmodule
`default_nettype wire

//--- design/lc4_memory_wb.sv
// Memory and writeback stages
`timescale 1ns/1ps
`include "lc4_settings.svh"
`default_nettype none

module lc4_memory_wb (
   input  wire                            gwe,
   input  wire                            i_rst_n,
   input  wire  lc4_pipe_pkg::ctrl_t      i_x_ctrl,
   input  wire  [`LC4_WORD_W-1:0]         i_x_pc,
   input  wire  [`LC4_WORD_W-1:0]         i_x_alu,
   input  wire  [2:0]                     i_x_nzp,
   input  wire  [`LC4_WORD_W-1:0]         i_x_rt,
   input  wire  [`LC4_WORD_W-1:0]         i_dmem_rdata,
   output logic [`LC4_WORD_W-1:0]         o_dmem_addr,
   output logic                           o_dmem_we,
   output logic [`LC4_WORD_W-1:0]         o_dmem_wdata,
   output logic [`LC4_WORD_W-1:0]         o_m_alu,
   output logic                           o_wb_valid,
   output logic [`LC4_WORD_W-1:0]         o_wb_pc,
   output logic                           o_wb_we,
   output logic [`LC4_REG_SEL_W-1:0]      o_wb_wsel,
   output logic [`LC4_WORD_W-1:0]         o_wb_data,
   output logic                           o_wb_nzp_we,
   output logic [2:0]                     o_wb_nzp,
   lc4_hazard_if.memwb                    hz
);

   lc4_pipe_pkg::ctrl_t    m_ctrl, w_ctrl;
   logic [`LC4_WORD_W-1:0] m_pc, m_rt, w_alu, w_rdata;
   logic [2:0]             m_nzp, w_nzp, ld_nzp;

   always_ff @(posedge gwe) begin
      if (!i_rst_n) begin
         m_ctrl <= '0;
         w_ctrl <= '0;
      end else begin
         m_ctrl <= i_x_ctrl;
         w_ctrl <= m_ctrl;
      end
   end

   always_ff @(posedge gwe) begin
      m_pc    <= i_x_pc;
      o_m_alu <= i_x_alu;
      m_nzp   <= i_x_nzp;
      m_rt    <= i_x_rt;
      o_wb_pc <= m_pc;
      w_alu   <= o_m_alu;
      w_nzp   <= m_nzp;
      w_rdata <= i_dmem_rdata;  // Load data taken at the end of M
   end

   // Data memory port belongs to the insn in M
   assign o_dmem_addr  = (m_ctrl.is_load || m_ctrl.is_store) ? o_m_alu : '0;
   assign o_dmem_we    = m_ctrl.is_store;
   assign o_dmem_wdata = hz.byp_st ? o_wb_data : m_rt;  // WM bypass

   // Loads get NZP from the loaded word
   assign ld_nzp = {w_rdata[15], w_rdata == '0, !w_rdata[15] && w_rdata != '0};

   assign o_wb_valid  = w_ctrl.valid;
   assign o_wb_we     = w_ctrl.regfile_we;
   assign o_wb_wsel   = w_ctrl.wsel;
   assign o_wb_data   = w_ctrl.is_load ? w_rdata : w_alu;
   assign o_wb_nzp_we = w_ctrl.nzp_we;
   assign o_wb_nzp    = w_ctrl.is_load ? ld_nzp : w_nzp;

   assign hz.m_wsel       = m_ctrl.wsel;
   assign hz.m_regfile_we = m_ctrl.regfile_we;
   assign hz.m_is_store   = m_ctrl.is_store;
   assign hz.m_r2sel      = m_ctrl.r2sel;   // Store data reg
   assign hz.w_wsel       = w_ctrl.wsel;
   assign hz.w_regfile_we = w_ctrl.regfile_we;

endmodule
`default_nettype wire

//--- design/lc4_core.sv
// LC4 five-stage pipeline top
`timescale 1ns/1ps
`include "lc4_settings.svh"
`default_nettype none

module lc4_core (
   input  wire                       gwe,
   input  wire                       i_rst_n,
   input  wire  [`LC4_WORD_W-1:0]    i_imem_data,
   input  wire  [`LC4_WORD_W-1:0]    i_dmem_rdata,
   output wire  [`LC4_WORD_W-1:0]    o_imem_addr,
   output wire  [`LC4_WORD_W-1:0]    o_dmem_addr,
   output wire                       o_dmem_we,
   output wire  [`LC4_WORD_W-1:0]    o_dmem_wdata,
   output wire                       o_wb_valid,   // Retirement trace
   output wire  [`LC4_WORD_W-1:0]    o_wb_pc,
   output wire                       o_wb_we,
   output wire  [`LC4_REG_SEL_W-1:0] o_wb_wsel,
   output wire  [`LC4_WORD_W-1:0]    o_wb_data,
   output wire                       o_wb_nzp_we,
   output wire  [2:0]                o_wb_nzp
);

   lc4_hazard_if hz ();

   lc4_pipe_pkg::ctrl_t    d_ctrl, x_ctrl;
   lc4_isa_pkg::insn_u     d_insn;
   logic [`LC4_WORD_W-1:0] d_pc, rs_data, rt_data;
   logic [`LC4_WORD_W-1:0] x_pc, x_alu, x_rt;
   logic [`LC4_WORD_W-1:0] m_alu;    // MX bypass source
   logic [2:0]             x_nzp;

   lc4_hazard_ctrl u_hazard (
      .hz (hz.ctrl)
   );

   // W writes back into the register file in D
   lc4_fetch_decode u_fetch_decode (
      .gwe         (gwe),
      .i_rst_n     (i_rst_n),
      .i_imem_data (i_imem_data),
      .i_wb_we     (o_wb_we),
      .i_wb_wsel   (o_wb_wsel),
      .i_wb_data   (o_wb_data),
      .o_imem_addr (o_imem_addr),
      .o_d_ctrl    (d_ctrl),
      .o_d_pc      (d_pc),
      .o_d_insn    (d_insn),
      .o_rs_data   (rs_data),
      .o_rt_data   (rt_data),
      .hz          (hz.decode)
   );

   lc4_execute u_execute (
      .gwe       (gwe),
      .i_rst_n   (i_rst_n),
      .i_d_ctrl  (d_ctrl),
      .i_d_pc    (d_pc),
      .i_d_insn  (d_insn),
      .i_rs_data (rs_data),
      .i_rt_data (rt_data),
      .i_m_alu   (m_alu),
      .i_w_data  (o_wb_data),  // WX bypass source
      .o_x_ctrl  (x_ctrl),
      .o_x_pc    (x_pc),
      .o_x_alu   (x_alu),
      .o_x_nzp   (x_nzp),
      .o_x_rt    (x_rt),
      .hz        (hz.execute)
   );

   lc4_memory_wb u_memory_wb (
      .gwe          (gwe),
      .i_rst_n      (i_rst_n),
      .i_x_ctrl     (x_ctrl),
      .i_x_pc       (x_pc),
      .i_x_alu      (x_alu),
      .i_x_nzp      (x_nzp),
      .i_x_rt       (x_rt),
      .i_dmem_rdata (i_dmem_rdata),
      .o_dmem_addr  (o_dmem_addr),
      .o_dmem_we    (o_dmem_we),
      .o_dmem_wdata (o_dmem_wdata),
      .o_m_alu      (m_alu),
      .o_wb_valid   (o_wb_valid),
      .o_wb_pc      (o_wb_pc),
      .o_wb_we      (o_wb_we),
      .o_wb_wsel    (o_wb_wsel),
      .o_wb_data    (o_wb_data),
      .o_wb_nzp_we  (o_wb_nzp_we),
      .o_wb_nzp     (o_wb_nzp),
      .hz           (hz.memwb)
   );

endmodule
`default_nettype wire

//--- sim/lc4_core_chk.sv
// LC4 core port assertions
`timescale 1ns/1ps
`default_nettype none

module lc4_core_chk (
   input wire        gwe,
   input wire        i_rst_n,
   input wire        o_dmem_we,
   input wire        o_wb_valid,
   input wire        o_wb_we,
   input wire [15:0] o_wb_pc
);

   logic [15:0] last_pc;      // PC of the previous retirement
   logic        seen_retire;

   always_ff @(posedge gwe) begin
      if (!i_rst_n) begin
         seen_retire <= 1'b0;
      end else if (o_wb_valid) begin
         seen_retire <= 1'b1;
         last_pc     <= o_wb_pc;
      end
   end

   // No store in reset or in the first cycle out of it
   a_no_store_in_reset: assert property (@(posedge gwe) !i_rst_n |-> o_dmem_we !== 1'b1)
      else $error("o_dmem_we high during reset");
   a_no_store_after_reset: assert property (@(posedge gwe) !i_rst_n |=> o_dmem_we !== 1'b1)
      else $error("o_dmem_we high right after reset");

   a_idle_after_reset: assert property (@(posedge gwe) !i_rst_n |=> o_wb_valid !== 1'b1)
      else $error("o_wb_valid high right after reset");

   a_we_needs_valid: assert property (@(posedge gwe) disable iff (!i_rst_n)
      o_wb_we |-> o_wb_valid)
      else $error("o_wb_we without o_wb_valid");

   // No redirects, so retirements walk the PC by one
   a_pc_steps: assert property (@(posedge gwe) disable iff (!i_rst_n)
      (o_wb_valid && seen_retire) |-> o_wb_pc == last_pc + 16'd1)
      else $error("o_wb_pc did not step by one");

endmodule

bind lc4_core lc4_core_chk u_chk (
   .gwe        (gwe),
   .i_rst_n    (i_rst_n),
   .o_dmem_we  (o_dmem_we),
   .o_wb_valid (o_wb_valid),
   .o_wb_we    (o_wb_we),
   .o_wb_pc    (o_wb_pc)
);
`default_nettype wire

//--- sim/lc4_core_tb.sv
// LC4 pipeline testbench
`timescale 1ns/1ps
`include "lc4_settings.svh"
`default_nettype none

module lc4_core_tb;

   localparam int CLK_PERIOD      = 8;
   localparam int PROG_LEN        = 60;
   localparam int SEED            = 24;
   localparam int WATCHDOG_CYCLES = 2 * PROG_LEN + 40;

   // Expected retirement, with the store it makes while in M
   typedef struct packed {
      logic [15:0] pc;
      logic        we;
      logic [2:0]  wsel;
      logic [15:0] data;
      logic        nzp_we;
      logic [2:0]  nzp;
      logic        st;
      logic [15:0] st_addr;
      logic [15:0] st_data;
      logic [3:0]  gap;      // Valid-low cycles right before this one
   } gold_t;

   logic        gwe;
   logic        i_rst_n;
   logic [15:0] i_imem_data;
   logic [15:0] i_dmem_rdata;
   wire  [15:0] o_imem_addr, o_dmem_addr, o_dmem_wdata, o_wb_pc, o_wb_data;
   wire         o_dmem_we, o_wb_valid, o_wb_we, o_wb_nzp_we;
   wire  [2:0]  o_wb_wsel, o_wb_nzp;

   logic [15:0] rom [256];    // Program at 8200h
   logic [15:0] ram [256];
   logic [15:0] g_regs [8];   // Golden model state
   logic [15:0] g_ram [256];
   logic        g_prev_load;
   logic [2:0]  g_prev_wsel;
   gold_t       gold_q[$];
   gold_t       store_q[$];
   int          prog_n;
   int          retired;
   int          idle;

   lc4_core uut (
      .gwe          (gwe),
      .i_rst_n      (i_rst_n),
      .i_imem_data  (i_imem_data),
      .i_dmem_rdata (i_dmem_rdata),
      .o_imem_addr  (o_imem_addr),
      .o_dmem_addr  (o_dmem_addr),
      .o_dmem_we    (o_dmem_we),
      .o_dmem_wdata (o_dmem_wdata),
      .o_wb_valid   (o_wb_valid),
      .o_wb_pc      (o_wb_pc),
      .o_wb_we      (o_wb_we),
      .o_wb_wsel    (o_wb_wsel),
      .o_wb_data    (o_wb_data),
      .o_wb_nzp_we  (o_wb_nzp_we),
      .o_wb_nzp     (o_wb_nzp)
   );

   always #(CLK_PERIOD / 2) gwe = ~gwe;

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TEST FAILED");
      $fatal(1, "run aborted");
   endtask

   task automatic check_eq(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
      if (actual !== expected) begin
         $display("ERROR %s expected %0h actual %0h", name, expected, actual);
         $display("TEST FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   function automatic logic [15:0] sext(input logic [15:0] v, input int bits);
      return 16'($signed(v << (16 - bits)) >>> (16 - bits));
   endfunction

   function automatic logic [2:0] nzp_of(input logic [15:0] v);
      if (v[15])
         return 3'b100;
      else if (v == 16'h0000)
         return 3'b010;
      return 3'b001;
   endfunction

   // Steps one instruction through the ISA rules
   function automatic gold_t lc4_golden(input logic [15:0] insn, input logic [15:0] pc);
      gold_t       g;
      logic [2:0]  rd, rs, rt;
      logic [15:0] a, b, addr;
      logic        use_rs, use_rt;
      rd     = insn[11:9];
      rs     = insn[8:6];
      rt     = insn[2:0];
      g      = '0;
      g.pc   = pc;
      use_rs = 1'b0;
      use_rt = 1'b0;
      case (insn[15:12])
         4'b0001: begin
            a      = g_regs[rs];
            use_rs = 1'b1;
            use_rt = !insn[5];
            b      = insn[5] ? sext(insn, 5) : g_regs[rt];
            g.data = (insn[5:3] == 3'b010) ? a - b : a + b;
            g.we   = 1'b1;
         end
         4'b1001: begin
            g.data = sext(insn, 9);
            g.we   = 1'b1;
         end
         4'b0110: begin
            addr   = g_regs[rs] + sext(insn, 6);
            g.data = g_ram[addr[7:0]];
            g.we   = 1'b1;
            use_rs = 1'b1;
         end
         4'b0111: begin
            addr      = g_regs[rs] + sext(insn, 6);
            g.st      = 1'b1;
            g.st_addr = addr;
            g.st_data = g_regs[rd];  // Data register sits in the rd field
            g_ram[addr[7:0]] = g_regs[rd];
            use_rs    = 1'b1;
         end
         default: ;  // Everything else writes nothing
      endcase
      if (g.we) begin
         g.wsel     = rd;
         g.nzp_we   = 1'b1;
         g.nzp      = nzp_of(g.data);
         g_regs[rd] = g.data;
      end
      // One bubble when the load just ahead feeds a source, store data excepted
      g.gap = (g_prev_load && ((use_rs && rs == g_prev_wsel) ||
                               (use_rt && rt == g_prev_wsel))) ? 4'd1 : 4'd0;
      g_prev_load = (insn[15:12] == 4'b0110);
      g_prev_wsel = rd;
      return g;
   endfunction

   task automatic put_insn(input logic [15:0] w);
      rom[8'(prog_n)] = w;
      prog_n++;
   endtask

   task automatic gen_program();
      int         kind;
      logic [2:0] rd, rs, rt, rb, rz, last_rd;
      logic [5:0] off;
      logic [3:0] op;
      last_rd = 3'd0;
      for (int r = 0; r < 8; r++)
         put_insn({4'b1001, 3'(r), 9'($urandom)});  // Every register gets a known value
      while (prog_n < PROG_LEN - 4) begin
         kind = int'($urandom % 7);
         rd   = 3'($urandom);
         rs   = ($urandom % 2 != 0) ? last_rd : 3'($urandom);  // Chain on last result
         rt   = 3'($urandom);
         rb   = 3'($urandom);
         rz   = 3'($urandom);
         off  = 6'($urandom);
         if ((kind == 4 && prog_n > PROG_LEN - 6) || (kind == 5 && prog_n > PROG_LEN - 7))
            kind = 0;
         case (kind)
            0: put_insn({4'b0001, rd, rs, 3'b000, rt});
            1: put_insn({4'b0001, rd, rs, 3'b010, rt});
            2: put_insn({4'b0001, rd, rs, 1'b1, 5'($urandom)});
            3: put_insn({4'b1001, rd, 9'($urandom)});
            4: begin
               put_insn({4'b0110, rd, rb, off});        // Load
               put_insn({4'b0001, rz, rd, 3'b000, rt}); // and its user
               rd = rz;
            end
            5: begin
               put_insn({4'b0001, rd, rs, 3'b010, rt});
               put_insn({4'b0111, rd, rb, off});  // Store of the fresh result
               put_insn({4'b0110, rz, rb, off});  // Read it back
               rd = rz;
            end
            default: begin
               do
                  op = 4'($urandom);
               while (op == 4'h1 || op == 4'h6 || op == 4'h7 || op == 4'h9);
               put_insn({op, 12'($urandom)});
               rd = last_rd;
            end
         endcase
         last_rd = rd;
      end
      while (prog_n < PROG_LEN)
         put_insn(16'h0000);  // Trailing NOPs
   endtask

   function automatic logic [15:0] imem_word(input logic [15:0] addr);
      logic [15:0] off;
      off = addr - `LC4_RESET_PC;
      if (off < 16'd256)
         return rom[off[7:0]];
      return 16'h0000;
   endfunction

   task automatic check_store();
      gold_t s;
      if (store_q.size() == 0) begin
         abort_run("data memory written with no store left in the program");
      end else begin
         s = store_q.pop_front();
         check_eq($sformatf("store pc %h addr", s.pc), 32'(s.st_addr), 32'(o_dmem_addr));
         check_eq($sformatf("store pc %h data", s.pc), 32'(s.st_data), 32'(o_dmem_wdata));
         ram[o_dmem_addr[7:0]] = o_dmem_wdata;
      end
   endtask

   task automatic check_retire();
      gold_t g;
      string tag;
      if (gold_q.size() == 0) begin
         abort_run("an instruction retired after the whole program had retired");
      end else begin
         g   = gold_q.pop_front();
         tag = $sformatf("retire %0d pc %h", retired, g.pc);
         // First retirement lands four cycles after reset
         check_eq({tag, " gap"}, (retired == 0) ? 32'd4 : 32'(g.gap), 32'(idle));
         check_eq({tag, " pc"}, 32'(g.pc), 32'(o_wb_pc));
         check_eq({tag, " we"}, 32'(g.we), 32'(o_wb_we));
         check_eq({tag, " nzp_we"}, 32'(g.nzp_we), 32'(o_wb_nzp_we));
         if (g.we) begin
            check_eq({tag, " wsel"}, 32'(g.wsel), 32'(o_wb_wsel));
            check_eq({tag, " data"}, 32'(g.data), 32'(o_wb_data));
         end
         if (g.nzp_we)
            check_eq({tag, " nzp"}, 32'(g.nzp), 32'(o_wb_nzp));
         retired++;
         idle = 0;
      end
   endtask

   initial begin
      gold_t g;
      void'($urandom(SEED));
      gwe          = 1'b0;
      i_rst_n      = 1'b0;
      i_imem_data  = 16'h0000;
      i_dmem_rdata = 16'h0000;
      prog_n       = 0;
      retired      = 0;
      idle         = 0;
      g_prev_load  = 1'b0;
      g_prev_wsel  = 3'd0;
      for (int i = 0; i < 256; i++) begin
         rom[8'(i)]   = 16'h0000;
         ram[8'(i)]   = 16'(i * 40503) ^ 16'h5a3c;  // Odd multiplier, unique per word
         g_ram[8'(i)] = ram[8'(i)];
      end
      for (int r = 0; r < 8; r++)
         g_regs[3'(r)] = 16'h0000;
      gen_program();
      for (int i = 0; i < PROG_LEN; i++) begin
         g = lc4_golden(rom[8'(i)], `LC4_RESET_PC + 16'(i));
         gold_q.push_back(g);
         if (g.st)
            store_q.push_back(g);
      end
      repeat (3) @(posedge gwe);
      #1 i_rst_n = 1'b1;
   end

   // Memories answer once PC and M have settled after the edge
   always @(posedge gwe) begin
      #1;
      i_imem_data  = imem_word(o_imem_addr);
      i_dmem_rdata = ram[o_dmem_addr[7:0]];
   end

   always @(negedge gwe) begin
      if (i_rst_n) begin
         if (retired == 0) begin
            if (idle == 0)
               check_eq("boot pc", 32'(`LC4_RESET_PC), 32'(o_imem_addr));
            check_eq("dmem_we before first retirement", 32'd0, 32'(o_dmem_we));
         end
         if (o_dmem_we === 1'b1)
            check_store();
         if (o_wb_valid === 1'b1) begin
            check_retire();
            if (gold_q.size() == 0) begin
               check_eq("stores never seen", 32'd0, 32'(store_q.size()));
               $display("TEST PASSED");
               $finish;
            end
         end else begin
            idle++;
         end
      end
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      abort_run($sformatf("timeout: only %0d of %0d instructions retired in %0d cycles",
                          retired, PROG_LEN, WATCHDOG_CYCLES));
   end

endmodule
`default_nettype wire

//--- filelist.f
+incdir+design
design/lc4_isa_pkg.sv
design/lc4_pipe_pkg.sv
design/lc4_hazard_if.sv
design/lc4_hazard_ctrl.sv
design/lc4_fetch_decode.sv
design/lc4_execute.sv
design/lc4_memory_wb.sv
design/lc4_core.sv
sim/lc4_core_chk.sv
sim/lc4_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := lc4_core_tb
FILELIST  := filelist.f
VFLAGS    := --binary --timing --assert
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard design/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
